/* Makefile */
# Verilator flow for the UART subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module uart_tb -f project.f

run: build
	@out="$$(./obj_dir/Vuart_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module uart_top \
		logic/uart_pkg.sv logic/uart_baud_gen.sv logic/tx_credit_buffer.sv \
		logic/uart_tx.sv logic/uart_rx.sv logic/rx_credit_buffer.sv \
		logic/uart_top.sv

clean:
	rm -rf obj_dir

/* dv/uart_tb.sv */
// UART subsystem testbench
`timescale 1ns/10ps

module uart_tb
  import uart_pkg::*;
();

  // Row modes
  localparam int M_LOOP = 0;
  localparam int M_HOLD = 1;
  localparam int M_GOOD = 2;
  localparam int M_BAD  = 3;

  typedef struct {
    int         mode;
    int         nbytes;
    logic [7:0] start;
    int         credits;
    int         exp_rx;
    int         exp_ovr;
    int         exp_ferr;
  } row_t;

  // Mode, byte count, start byte, rx credits, rx bytes, overruns, frame errors
  row_t rows [$] = '{
    '{M_LOOP, 6, 8'hA5, 6, 6, 0, 0},
    '{M_HOLD, 4, 8'h3C, 4, 4, 0, 0},
    '{M_HOLD, 6, 8'h81, 4, 4, 2, 0},
    '{M_BAD,  1, 8'h5A, 1, 0, 0, 1},
    '{M_GOOD, 1, 8'hC3, 1, 1, 0, 0},
    '{M_LOOP, 3, 8'hFF, 3, 3, 0, 0}
  };

  // DUT inputs
  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       tx_push = 1'b0;
  logic [7:0] tx_data = 8'h00;
  logic       rx_credit = 1'b0;
  logic       rxd;
  // Serial mux controls
  logic       loopback = 1'b0;
  logic       inj_rxd = 1'b1;
  // DUT outputs
  logic       tx_credit;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       rx_overrun;
  logic       rx_frame_err;
  logic       txd;

  // Scoreboard state
  int          errors = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  int          pushes = 0;
  int          returns = 0;
  int          rx_cnt = 0;
  int          ovr_cnt = 0;
  int          ferr_cnt = 0;
  logic [7:0]  exp_q [$];
  logic [7:0]  row_bytes [$];
  logic [31:0] lcg_state = 32'd57;

  always #10 clk = ~clk;

  // Loopback follows txd, inject mode is bit-banged
  assign rxd = loopback ? txd : inj_rxd;

  uart_top uut (
    .clk          (clk),
    .rst          (rst),
    .tx_push      (tx_push),
    .tx_data      (tx_data),
    .tx_credit    (tx_credit),
    .rx_credit    (rx_credit),
    .rx_valid     (rx_valid),
    .rx_data      (rx_data),
    .rx_overrun   (rx_overrun),
    .rx_frame_err (rx_frame_err),
    .txd          (txd),
    .rxd          (rxd)
  );

  // ******************************************************************
  // Helpers
  // ******************************************************************
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string mode_name(input int mode);
    case (mode)
      M_LOOP:  return "loopback burst";
      M_HOLD:  return "withheld credit";
      M_GOOD:  return "inject good";
      default: return "inject bad stop";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before)
    begin
      tests_pass++;
      $display("Test %s: passed", name);
    end
    else
    begin
      tests_fail++;
      $display("Test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // Host push, only while a transmit credit is held
  task automatic push_byte(input logic [7:0] b);
    while (pushes - returns >= TX_DEPTH)
    begin
      @(posedge clk);
    end
    @(posedge clk);
    tx_push <= 1'b1;
    tx_data <= b;
    pushes++;
    @(posedge clk);
    tx_push <= 1'b0;
  endtask

  // One-cycle receive grant
  task automatic grant_credit();
    @(posedge clk);
    rx_credit <= 1'b1;
    @(posedge clk);
    rx_credit <= 1'b0;
  endtask

  // 8N1 frame onto rxd, LSB first
  task automatic send_serial(input logic [7:0] b, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      inj_rxd <= bits[0];
      bits = bits >> 1;
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
    @(posedge clk);
    inj_rxd <= 1'b1;
  endtask

  // Every cycle of a frame checked against start, data and stop bits
  task automatic check_frame(input logic [7:0] b);
    logic [9:0] bits;
    int         n;
    int         bit_no;
    bits = {1'b1, b, 1'b0};
    n = 0;
    bit_no = 0;
    do
    begin
      @(posedge clk);
      n++;
    end while (txd && n < 4 * BIT_CLKS);
    if (txd)
    begin
      report_error("no start bit seen on txd");
      return;
    end
    for (int t = 0; t < 10 * BIT_CLKS; t++)
    begin
      if (t > 0)
      begin
        @(posedge clk);
      end
      // Next bit begins every BIT_CLKS cycles
      if (t > 0 && (t % BIT_CLKS) == 0)
      begin
        bits = bits >> 1;
        bit_no++;
      end
      if (txd !== bits[0])
      begin
        compare($sformatf("txd bit %0d", bit_no), 32'(txd), 32'(bits[0]));
        break;
      end
    end
  endtask

  task automatic wait_rx(input int target, input int limit);
    int n;
    n = 0;
    while (rx_cnt < target && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (rx_cnt < target)
    begin
      report_error("timed out waiting for a received byte on rx_valid");
    end
  endtask

  // ******************************************************************
  // Output monitor
  // ******************************************************************
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (tx_credit)
      begin
        returns++;
      end
      if (rx_overrun)
      begin
        ovr_cnt++;
      end
      if (rx_frame_err)
      begin
        ferr_cnt++;
      end
      if (rx_valid)
      begin
        rx_cnt++;
        // Bytes must come back in push order
        if (exp_q.size() == 0)
        begin
          report_error("rx_valid with no byte expected");
        end
        else
        begin
          compare("rx_data", 32'(rx_data), 32'(exp_q.pop_front()));
        end
      end
    end
  end

  // ******************************************************************
  // Test sequence
  // ******************************************************************
  initial
  begin
    int err0;
    int base_rx;
    int base_ovr;
    int base_ferr;
    int base_ret;
    int base_push;
    int n;
    int nb;
    int mode;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs after reset, no stimulus
    err0 = errors;
    for (int c = 0; c < 2 * BIT_CLKS; c++)
    begin
      @(posedge clk);
      if ({txd, rx_valid, tx_credit, rx_overrun, rx_frame_err} !== 5'b10000)
      begin
        compare("txd", 32'(txd), 32'd1);
        compare("rx_valid", 32'(rx_valid), 32'd0);
        compare("tx_credit", 32'(tx_credit), 32'd0);
        compare("rx_overrun", 32'(rx_overrun), 32'd0);
        compare("rx_frame_err", 32'(rx_frame_err), 32'd0);
        break;
      end
    end
    finish_test("reset state", err0);

    for (int r = 0; r < rows.size(); r++)
    begin
      err0 = errors;
      base_rx = rx_cnt;
      base_ovr = ovr_cnt;
      base_ferr = ferr_cnt;
      base_ret = returns;
      base_push = pushes;
      mode = rows[r].mode;
      nb = rows[r].nbytes;
      row_bytes.delete();
      // Start byte, then LCG values
      for (int k = 0; k < nb; k++)
      begin
        if (k == 0)
        begin
          row_bytes.push_back(rows[r].start);
        end
        else
        begin
          lcg_state = lcg_next(lcg_state);
          row_bytes.push_back(lcg_state[23:16]);
        end
        // Arrivals past RX_DEPTH are lost while credits are withheld
        if (mode == M_LOOP || mode == M_GOOD || (mode == M_HOLD && k < RX_DEPTH))
        begin
          exp_q.push_back(row_bytes[k]);
        end
      end
      @(posedge clk);
      loopback <= (mode == M_LOOP || mode == M_HOLD);

      case (mode)
        M_LOOP:
        begin
          for (int k = 0; k < rows[r].credits; k++)
          begin
            grant_credit();
          end
          fork
            begin
              for (int k = 0; k < nb; k++)
              begin
                push_byte(row_bytes[k]);
              end
            end
            begin
              for (int k = 0; k < nb; k++)
              begin
                check_frame(row_bytes[k]);
              end
            end
          join
          wait_rx(base_rx + rows[r].exp_rx, 12 * BIT_CLKS);
        end
        M_HOLD:
        begin
          for (int k = 0; k < nb; k++)
          begin
            push_byte(row_bytes[k]);
          end
          n = 0;
          while (returns - base_ret < nb && n < nb * 12 * BIT_CLKS)
          begin
            @(posedge clk);
            n++;
          end
          if (returns - base_ret < nb)
          begin
            report_error("timed out waiting for tx_credit returns");
          end
          // Last frame lands in the receive buffer
          repeat (11 * BIT_CLKS) @(posedge clk);
          compare("rx_valid count before grant", rx_cnt - base_rx, 0);
          // Each grant releases exactly one byte
          for (int k = 0; k < rows[r].credits; k++)
          begin
            grant_credit();
            wait_rx(base_rx + k + 1, 16);
            repeat (4) @(posedge clk);
            compare("rx_valid count after grant", rx_cnt - base_rx, k + 1);
          end
        end
        default:
        begin
          for (int k = 0; k < rows[r].credits; k++)
          begin
            grant_credit();
          end
          send_serial(row_bytes[0], mode == M_GOOD);
          wait_rx(base_rx + rows[r].exp_rx, 4 * BIT_CLKS);
        end
      endcase

      // Receiver back to idle, stray pulses counted
      repeat (3 * BIT_CLKS) @(posedge clk);
      compare("rx_valid count", rx_cnt - base_rx, rows[r].exp_rx);
      compare("rx_overrun count", ovr_cnt - base_ovr, rows[r].exp_ovr);
      compare("rx_frame_err count", ferr_cnt - base_ferr, rows[r].exp_ferr);
      compare("tx_credit count", returns - base_ret, pushes - base_push);
      if (exp_q.size() != 0)
      begin
        report_error("expected bytes never came out on rx_data");
        exp_q.delete();
      end
      finish_test($sformatf("row %0d (%s)", r, mode_name(mode)), err0);
    end

    $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (errors == 0 && tests_fail == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // ******************************************************************
  // Watchdog
  // ******************************************************************
  initial
  begin
    int limit_cycles;
    limit_cycles = 0;
    for (int r = 0; r < rows.size(); r++)
    begin
      limit_cycles += rows[r].nbytes * 12 * BIT_CLKS;
    end
    // Margin for reset, settling and grants
    limit_cycles += (rows.size() + 2) * 24 * BIT_CLKS;
    #(limit_cycles * 20);
    $display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* logic/rx_credit_buffer.sv */
// Receive credit buffer
`timescale 1ns/10ps

module rx_credit_buffer
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_strobe,
  input  logic [7:0] rx_byte,
  input  logic       rx_credit,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       rx_overrun
);

  // Storage, pointers and counters
  logic [7:0]            mem [RX_DEPTH];
  logic [RX_PTR_WID-1:0] wr_ptr;
  logic [RX_PTR_WID-1:0] rd_ptr;
  logic [CREDIT_WID-1:0] count;
  logic [CREDIT_WID-1:0] credits;
  logic                  full;
  logic                  push;
  // Byte handed to the host this cycle
  logic                  present;

  assign full    = (count == CREDIT_WID'(RX_DEPTH));
  assign push    = rx_strobe && !full;
  // A grant arriving this cycle can be spent at once
  assign present = (count != '0) && ((credits != '0) || rx_credit);

  // ******************************************************************
  // Pointers, occupancy and credit count
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= '0;
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end
    else
    begin
      rx_valid   <= present;
      // Arrival while full drops the byte
      rx_overrun <= rx_strobe && full;
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (present)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CREDIT_WID'(push) - CREDIT_WID'(present);
      // Grant adds, presentation spends
      case ({rx_credit, present})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Byte storage and output data
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= rx_byte;
    end
    if (present)
    begin
      rx_data <= mem[rd_ptr];
    end
  end

  // Every presented byte was backed by a credit
  a_valid_credit : assert property (@(posedge clk) disable iff (rst)
    rx_valid |-> ($past(credits) != '0) || $past(rx_credit))
    else $error("rx_valid without a receive credit");

endmodule

/* logic/tx_credit_buffer.sv */
// Transmit credit buffer
`timescale 1ns/10ps

module tx_credit_buffer
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_push,
  input  logic [7:0] tx_data,
  input  logic       tx_take,
  output logic       tx_avail,
  output logic [7:0] tx_byte,
  output logic       tx_credit
);

  // Storage and pointers
  logic [7:0]            mem [TX_DEPTH];
  logic [TX_PTR_WID-1:0] wr_ptr;
  logic [TX_PTR_WID-1:0] rd_ptr;
  logic [CREDIT_WID-1:0] count;
  // Qualified push and pop
  logic                  push;
  logic                  pop;
  logic                  full;

  assign full     = (count == CREDIT_WID'(TX_DEPTH));
  assign push     = tx_push && !full;
  assign pop      = tx_take && tx_avail;
  assign tx_avail = (count != '0);
  assign tx_byte  = mem[rd_ptr];

  // Each byte leaving the buffer returns one credit to the host
  assign tx_credit = pop;

  // ******************************************************************
  // Pointers and occupancy
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CREDIT_WID'(push) - CREDIT_WID'(pop);
    end
  end

  // Byte storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= tx_data;
    end
  end

  // Host pushed without a credit
  a_no_push_full : assert property (@(posedge clk) disable iff (rst)
    tx_push |-> !full)
    else $error("tx_push while transmit buffer full");

endmodule

/* logic/uart_baud_gen.sv */
// 16x baud enable generator
`timescale 1ns/10ps

module uart_baud_gen
  import uart_pkg::*;
(
  input  logic clk,
  input  logic rst,
  output logic baud_x16_en
);

  // Divider state
  logic [CNT_WID-1:0] count;
  logic [CNT_WID-1:0] count_m_1;

  // Next count value
  assign count_m_1 = count - 1'b1;

  // ******************************************************************
  // Down-counter with registered enable
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count       <= CNT_WID'(DIVIDER - 1);
      baud_x16_en <= 1'b0;
    end
    else
    begin
      // Enable lands in the cycle the count reaches zero
      baud_x16_en <= (count_m_1 == '0);
      // Reload at DIVIDER minus one after zero
      if (count == '0)
      begin
        count <= CNT_WID'(DIVIDER - 1);
      end
      else
      begin
        count <= count_m_1;
      end
    end
  end

  // Enable is a single-cycle pulse
  a_en_single : assert property (@(posedge clk) disable iff (rst)
    baud_x16_en |=> !baud_x16_en)
    else $error("baud_x16_en high in two consecutive cycles");

endmodule

/* logic/uart_pkg.sv */
// UART subsystem constants
package uart_pkg;

  // ******************************************************************
  // Rates and baud divider
  // ******************************************************************

  // System clock and serial line rate
  localparam int CLOCK_RATE = 50_000_000;
  localparam int BAUD_RATE  = 781_250;

  // 16x oversampling rate
  localparam int OVERSAMPLE_RATE = BAUD_RATE * 16;

  // Clocks per 16x enable, rounded to nearest, must be 2 or more
  localparam int DIVIDER = (CLOCK_RATE + OVERSAMPLE_RATE / 2) / OVERSAMPLE_RATE;
  localparam int CNT_WID = $clog2(DIVIDER);

  // Clocks per serial bit
  localparam int BIT_CLKS = 16 * DIVIDER;

  // ******************************************************************
  // Buffers and credits
  // ******************************************************************

  // Depths are powers of two so the pointers wrap on their own
  localparam int TX_DEPTH   = 4;
  localparam int RX_DEPTH   = 4;
  localparam int TX_PTR_WID = $clog2(TX_DEPTH);
  localparam int RX_PTR_WID = $clog2(RX_DEPTH);

  // Spare bits let the host grant receive credits well ahead of data
  localparam int MAX_DEPTH  = (TX_DEPTH > RX_DEPTH) ? TX_DEPTH : RX_DEPTH;
  localparam int CREDIT_WID = $clog2(MAX_DEPTH + 1) + 2;

  // ******************************************************************
  // Serial FSM encodings, shared by transmitter and receiver
  // ******************************************************************
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  // Last tick of a bit, and the mid-start sample
  localparam logic [3:0] TICK_LAST = 4'd15;
  localparam logic [3:0] TICK_HALF = 4'd7;

endpackage

/* logic/uart_rx.sv */
// UART oversampling receiver
`timescale 1ns/10ps

module uart_rx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       baud_x16_en,
  input  logic       rxd,
  output logic       rx_strobe,
  output logic [7:0] rx_byte,
  output logic       rx_frame_err
);

  // Two-flop synchronizer
  logic       rxd_meta;
  logic       rxd_sync;
  // FSM state and counters
  logic [1:0] state;
  logic [3:0] tick_cnt;
  logic [2:0] bit_idx;
  // Assembled byte
  logic [7:0] shift_reg;
  // Mid-bit data sample
  logic       data_sample;

  assign data_sample = baud_x16_en && (tick_cnt == TICK_LAST) && (state == ST_DATA);

  // Byte is stable through the stop bit
  assign rx_byte = shift_reg;

  // ******************************************************************
  // Input synchronizer
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end
    else
    begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // ******************************************************************
  // Frame FSM
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= ST_IDLE;
      tick_cnt     <= '0;
      bit_idx      <= '0;
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
    end
    else
    begin
      // Status outputs are single-cycle pulses
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
      if (baud_x16_en)
      begin
        case (state)
          ST_IDLE:
          begin
            // Low level starts the half-bit count
            if (!rxd_sync)
            begin
              state    <= ST_START;
              tick_cnt <= '0;
            end
          end
          ST_START:
          begin
            if (tick_cnt == TICK_HALF)
            begin
              tick_cnt <= '0;
              bit_idx  <= '0;
              // Glitch if high again at mid start bit
              state    <= rxd_sync ? ST_IDLE : ST_DATA;
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          ST_DATA:
          begin
            if (tick_cnt == TICK_LAST)
            begin
              tick_cnt <= '0;
              if (bit_idx == 3'd7)
              begin
                state <= ST_STOP;
              end
              else
              begin
                bit_idx <= bit_idx + 1'b1;
              end
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          ST_STOP:
          begin
            if (tick_cnt == TICK_LAST)
            begin
              // Mid stop bit decides the outcome
              state        <= ST_IDLE;
              tick_cnt     <= '0;
              rx_strobe    <= rxd_sync;
              rx_frame_err <= !rxd_sync;
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          default:
          begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk)
  begin
    if (data_sample)
    begin
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
  end

  a_status_excl : assert property (@(posedge clk) disable iff (rst)
    !(rx_strobe && rx_frame_err))
    else $error("rx_strobe and rx_frame_err high together");

endmodule

/* logic/uart_top.sv */
// UART subsystem top level
`timescale 1ns/10ps

module uart_top (
  input  logic       clk,
  input  logic       rst,
  // Host transmit side
  input  logic       tx_push,
  input  logic [7:0] tx_data,
  output logic       tx_credit,
  // Host receive side
  input  logic       rx_credit,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       rx_overrun,
  output logic       rx_frame_err,
  // Serial line
  output logic       txd,
  input  logic       rxd
);

  // Shared 16x enable
  logic       baud_x16_en;
  // Buffer to serializer
  logic       tx_avail;
  logic [7:0] tx_byte;
  logic       tx_take;
  // Receiver to buffer
  logic       rx_strobe;
  logic [7:0] rx_byte;

  // ******************************************************************
  // Baud generator
  // ******************************************************************
  uart_baud_gen u_baud_gen (
    .clk         (clk),
    .rst         (rst),
    .baud_x16_en (baud_x16_en)
  );

  // ******************************************************************
  // Transmit path
  // ******************************************************************
  tx_credit_buffer u_tx_buf (
    .clk       (clk),
    .rst       (rst),
    .tx_push   (tx_push),
    .tx_data   (tx_data),
    .tx_take   (tx_take),
    .tx_avail  (tx_avail),
    .tx_byte   (tx_byte),
    .tx_credit (tx_credit)
  );

  uart_tx u_tx (
    .clk         (clk),
    .rst         (rst),
    .baud_x16_en (baud_x16_en),
    .tx_avail    (tx_avail),
    .tx_byte     (tx_byte),
    .tx_take     (tx_take),
    .txd         (txd)
  );

  // ******************************************************************
  // Receive path
  // ******************************************************************
  uart_rx u_rx (
    .clk          (clk),
    .rst          (rst),
    .baud_x16_en  (baud_x16_en),
    .rxd          (rxd),
    .rx_strobe    (rx_strobe),
    .rx_byte      (rx_byte),
    .rx_frame_err (rx_frame_err)
  );

  rx_credit_buffer u_rx_buf (
    .clk        (clk),
    .rst        (rst),
    .rx_strobe  (rx_strobe),
    .rx_byte    (rx_byte),
    .rx_credit  (rx_credit),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .rx_overrun (rx_overrun)
  );

endmodule

/* logic/uart_tx.sv */
// UART 8N1 serializer
`timescale 1ns/10ps

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       baud_x16_en,
  input  logic       tx_avail,
  input  logic [7:0] tx_byte,
  output logic       tx_take,
  output logic       txd
);

  // FSM state and counters
  logic [1:0] state;
  logic [3:0] tick_cnt;
  logic [2:0] bit_idx;
  // Byte being sent, shifted LSB first
  logic [7:0] shift_reg;
  // Last tick of the current bit
  logic       bit_end;

  assign bit_end = baud_x16_en && (tick_cnt == TICK_LAST);

  // Take a byte when idle, or at the end of a stop bit for back-to-back frames
  assign tx_take = tx_avail && baud_x16_en &&
                   ((state == ST_IDLE) || ((state == ST_STOP) && (tick_cnt == TICK_LAST)));

  // ******************************************************************
  // Frame FSM and line driver
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      txd      <= 1'b1;
    end
    else if (tx_take)
    begin
      // Start bit begins on the next cycle
      state    <= ST_START;
      tick_cnt <= '0;
      txd      <= 1'b0;
    end
    else if (baud_x16_en)
    begin
      case (state)
        ST_START:
        begin
          if (bit_end)
          begin
            state    <= ST_DATA;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= shift_reg[0];
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_DATA:
        begin
          if (bit_end)
          begin
            tick_cnt <= '0;
            if (bit_idx == 3'd7)
            begin
              // Stop bit
              state <= ST_STOP;
              txd   <= 1'b1;
            end
            else
            begin
              // Next bit comes from position 1, before the shift lands
              bit_idx <= bit_idx + 1'b1;
              txd     <= shift_reg[1];
            end
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_STOP:
        begin
          // No byte waiting at the end of the stop bit
          if (bit_end)
          begin
            state <= ST_IDLE;
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Shift register, loaded on take
  always_ff @(posedge clk)
  begin
    if (tx_take)
    begin
      shift_reg <= tx_byte;
    end
    else if (bit_end && (state == ST_DATA))
    begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

  // Line idles high
  a_idle_high : assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE) |-> txd)
    else $error("txd low while transmitter idle");

endmodule

/* project.f */
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/tx_credit_buffer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/rx_credit_buffer.sv
logic/uart_top.sv
dv/uart_tb.sv
